//--- include/i2c_axi_settings.svh
`ifndef I2C_AXI_SETTINGS_SVH
`define I2C_AXI_SETTINGS_SVH

// entries per byte FIFO
`define I2C_FIFO_DEPTH 16

// clk cycles per quarter of an SCL period
`define I2C_CLK_DIV 4

// register word addresses
`define ADDR_SETUP0  32'd0
`define ADDR_SETUP1  32'd1
`define ADDR_FLAG    32'd2
`define ADDR_FIFO_WR 32'd3
`define ADDR_FIFO_RD 32'd4

`endif

//--- design/i2c_axi_pkg.sv
package i2c_axi_pkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01
    } axi_burst_t;

    // length 0 means a single byte
    typedef struct packed {
        logic [6:0]  slave_addr;
        logic        read;
        logic [15:0] length;
    } i2c_cmd_t;

endpackage

//--- design/i2c_axi_if.sv
`timescale 1ns/100ps

// register write port, one strobe per accepted in-range beat
interface reg_wr_if;
    logic        wr_en;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_strb;
    logic        tx_full;

    modport chan (output wr_en, wr_addr, wr_data, wr_strb, input tx_full);
    modport regs (input wr_en, wr_addr, wr_data, wr_strb, output tx_full);
endinterface

// register read port, data is muxed combinationally from rd_addr
interface reg_rd_if;
    logic [31:0] rd_addr;
    logic [31:0] rd_data;
    logic        rx_empty;
    logic        rd_pop;

    modport chan (output rd_addr, rd_pop, input rd_data, rx_empty);
    modport regs (input rd_addr, rd_pop, output rd_data, rx_empty);
endinterface

//--- design/i2c_byte_fifo.sv
`timescale 1ns/100ps
`include "i2c_axi_settings.svh"

module i2c_byte_fifo (
    input  logic       clk,
    input  logic       I2C_MASTER_AXI_SLAVE_RSTN_SYNC,
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic       pop,
    output logic [7:0] pop_data,
    output logic       full,
    output logic       empty
);

    localparam int DEPTH = `I2C_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    logic [7:0]    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign full     = (count == (AW+1)'(DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;    // overflow is dropped
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];      // fall-through head

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or negedge I2C_MASTER_AXI_SLAVE_RSTN_SYNC) begin
        if (!I2C_MASTER_AXI_SLAVE_RSTN_SYNC) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + (AW+1)'(do_push) - (AW+1)'(do_pop);
        end
    end

endmodule

//--- design/axi_wr_channel.sv
`timescale 1ns/100ps
`include "i2c_axi_settings.svh"

module axi_wr_channel (
    input  logic        clk,
    input  logic        I2C_MASTER_AXI_SLAVE_RSTN_SYNC,
    input  logic [3:0]  awid,
    input  logic [31:0] awaddr,
    input  logic [1:0]  awburst,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wlast,
    input  logic        wvalid,
    output logic        wready,
    output logic [3:0]  bid,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    reg_wr_if.chan      wr
);

    typedef enum logic [1:0] {ST_IDLE, ST_DATA, ST_RESP} state_t;

    state_t                  state;
    logic [3:0]              id_q;
    logic [31:0]             addr_q;
    i2c_axi_pkg::axi_burst_t burst_q;
    logic                    err_q;     // sticky over the burst
    logic                    beat;
    logic                    beat_bad;

    assign awready  = (state == ST_IDLE);
    // stall only when pushing into a full tx FIFO
    assign wready   = (state == ST_DATA) && !(addr_q == `ADDR_FIFO_WR && wr.tx_full);
    assign bvalid   = (state == ST_RESP);
    assign bid      = id_q;
    assign bresp    = err_q ? i2c_axi_pkg::RESP_SLVERR : i2c_axi_pkg::RESP_OKAY;
    assign beat     = wvalid && wready;
    assign beat_bad = (addr_q >= `ADDR_FIFO_RD);   // FIFO_RD is read only

    assign wr.wr_en   = beat && !beat_bad;
    assign wr.wr_addr = addr_q;
    assign wr.wr_data = wdata;
    assign wr.wr_strb = wstrb;

    always_ff @(posedge clk or negedge I2C_MASTER_AXI_SLAVE_RSTN_SYNC) begin
        if (!I2C_MASTER_AXI_SLAVE_RSTN_SYNC) begin
            state   <= ST_IDLE;
            err_q   <= 1'b0;
            id_q    <= 4'd0;
            addr_q  <= 32'd0;
            burst_q <= i2c_axi_pkg::BURST_FIXED;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (awvalid) begin
                        state   <= ST_DATA;
                        err_q   <= 1'b0;
                        id_q    <= awid;
                        addr_q  <= awaddr;
                        burst_q <= i2c_axi_pkg::axi_burst_t'(awburst);
                    end
                end
                ST_DATA: begin
                    if (beat) begin
                        if (beat_bad)
                            err_q <= 1'b1;
                        if (burst_q == i2c_axi_pkg::BURST_INCR)
                            addr_q <= addr_q + 32'd1;
                        if (wlast)
                            state <= ST_RESP;   // awlen is not tracked
                    end
                end
                ST_RESP: if (bready) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- design/axi_rd_channel.sv
`timescale 1ns/100ps
`include "i2c_axi_settings.svh"

module axi_rd_channel (
    input  logic        clk,
    input  logic        I2C_MASTER_AXI_SLAVE_RSTN_SYNC,
    input  logic [3:0]  arid,
    input  logic [31:0] araddr,
    input  logic [7:0]  arlen,
    input  logic [1:0]  arburst,
    input  logic        arvalid,
    output logic        arready,
    output logic [3:0]  rid,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready,
    reg_rd_if.chan      rd
);

    typedef enum logic {ST_IDLE, ST_DATA} state_t;

    state_t                  state;
    logic [3:0]              id_q;
    logic [31:0]             addr_q;
    logic [7:0]              cnt_q;     // beats left after this one
    i2c_axi_pkg::axi_burst_t burst_q;
    logic                    beat_bad;
    logic                    is_fifo;
    logic                    beat;
    logic [31:0]             live_data;
    logic [31:0]             held_data; // beat data frozen during a stall
    logic                    held;

    assign arready   = (state == ST_IDLE);
    assign beat_bad  = (addr_q > `ADDR_FIFO_RD);
    assign is_fifo   = (addr_q == `ADDR_FIFO_RD);
    // fifo beats wait for data, error beats go out at once
    assign rvalid    = (state == ST_DATA) && (!is_fifo || !rd.rx_empty);
    assign rlast     = (state == ST_DATA) && (cnt_q == 8'd0);
    assign rid       = id_q;
    assign live_data = beat_bad ? 32'd0 : rd.rd_data;
    assign rdata     = held ? held_data : live_data;
    assign rresp     = beat_bad ? i2c_axi_pkg::RESP_SLVERR : i2c_axi_pkg::RESP_OKAY;
    assign beat      = rvalid && rready;

    assign rd.rd_addr = addr_q;
    assign rd.rd_pop  = beat && is_fifo;

    always_ff @(posedge clk or negedge I2C_MASTER_AXI_SLAVE_RSTN_SYNC) begin
        if (!I2C_MASTER_AXI_SLAVE_RSTN_SYNC) begin
            state     <= ST_IDLE;
            id_q      <= 4'd0;
            addr_q    <= 32'd0;
            cnt_q     <= 8'd0;
            burst_q   <= i2c_axi_pkg::BURST_FIXED;
            held      <= 1'b0;
            held_data <= 32'd0;
        end else begin
            if (rvalid && !rready) begin
                held <= 1'b1;
                if (!held)
                    held_data <= live_data;
            end else begin
                held <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    if (arvalid) begin
                        state   <= ST_DATA;
                        id_q    <= arid;
                        addr_q  <= araddr;
                        cnt_q   <= arlen;
                        burst_q <= i2c_axi_pkg::axi_burst_t'(arburst);
                    end
                end
                ST_DATA: begin
                    if (beat) begin
                        if (burst_q == i2c_axi_pkg::BURST_INCR)
                            addr_q <= addr_q + 32'd1;
                        if (rlast)
                            state <= ST_IDLE;
                        else
                            cnt_q <= cnt_q - 8'd1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- design/i2c_byte_engine.sv
`timescale 1ns/100ps
`include "i2c_axi_settings.svh"

module i2c_byte_engine (
    input  logic                  clk,
    input  logic                  I2C_MASTER_AXI_SLAVE_RSTN_SYNC,
    input  i2c_axi_pkg::i2c_cmd_t cmd,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    output logic                  cmd_done,
    output logic                  cmd_error,
    output logic                  scl_out,
    output logic                  scl_enable,
    input  logic                  sda_in,
    output logic                  sda_out,
    output logic                  sda_enable,
    output logic                  tx_pop,
    input  logic [7:0]            tx_byte,
    output logic                  rx_push,
    output logic [7:0]            rx_byte
);

    localparam int DW = $clog2(`I2C_CLK_DIV + 1);

    typedef enum logic [2:0] {ST_IDLE, ST_START, ST_ADDR, ST_DATA, ST_STOP} state_t;

    state_t        state;
    logic [DW-1:0] div_cnt;
    logic          tick;
    logic [1:0]    q;           // quarter within the current bit
    logic [3:0]    bit_cnt;     // 8 is the ack slot
    logic [7:0]    sh;
    logic [15:0]   left;        // bytes after the current one
    logic          rd_q;
    logic          ack_n;
    logic          err;
    logic          rx_phase;
    logic          bit_end;

    assign tick      = (div_cnt == DW'(`I2C_CLK_DIV - 1));
    assign bit_end   = tick && (q == 2'd3);
    assign rx_phase  = (state == ST_DATA) && rd_q;
    assign cmd_ready = (state == ST_IDLE);
    assign cmd_error = err;
    assign rx_byte   = sh;

    // scl is high in quarters 1 and 2 of each bit
    assign scl_enable = (state != ST_IDLE);
    always_comb begin
        case (state)
            ST_IDLE:  scl_out = 1'b1;
            ST_START: scl_out = (q < 2'd2);
            ST_STOP:  scl_out = (q != 2'd0);
            default:  scl_out = (q == 2'd1) || (q == 2'd2);
        endcase
    end

    always_comb begin
        sda_enable = 1'b1;
        sda_out    = 1'b1;
        case (state)
            ST_IDLE:  sda_enable = 1'b0;
            ST_START: sda_out = (q == 2'd0);    // falls while scl high
            ST_STOP:  sda_out = (q >= 2'd2);    // rises while scl high
            default: begin
                if (bit_cnt == 4'd8) begin
                    sda_enable = rx_phase;      // master acks only on reads
                    sda_out    = (left == 16'd0);   // nack the last byte
                end else begin
                    sda_enable = !rx_phase;
                    sda_out    = sh[3'd7 - bit_cnt[2:0]];
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge I2C_MASTER_AXI_SLAVE_RSTN_SYNC) begin
        if (!I2C_MASTER_AXI_SLAVE_RSTN_SYNC) begin
            state    <= ST_IDLE;
            div_cnt  <= '0;
            q        <= 2'd0;
            bit_cnt  <= 4'd0;
            sh       <= 8'd0;
            left     <= 16'd0;
            rd_q     <= 1'b0;
            ack_n    <= 1'b1;
            err      <= 1'b0;
            cmd_done <= 1'b0;
            tx_pop   <= 1'b0;
            rx_push  <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            tx_pop   <= 1'b0;
            rx_push  <= 1'b0;
            if (tx_pop)
                sh <= tx_byte;      // byte at the head when popped
            if (state == ST_IDLE) begin
                div_cnt <= '0;
                q       <= 2'd0;
                if (cmd_valid) begin
                    state   <= ST_START;
                    sh      <= {cmd.slave_addr, cmd.read};
                    rd_q    <= cmd.read;
                    left    <= cmd.length;
                    bit_cnt <= 4'd0;
                    err     <= 1'b0;
                end
            end else begin
                div_cnt <= tick ? '0 : div_cnt + 1'b1;
                if (tick)
                    q <= q + 2'd1;
                // sample in the middle of scl high
                if (tick && q == 2'd1 && (state == ST_ADDR || state == ST_DATA)) begin
                    if (bit_cnt == 4'd8)
                        ack_n <= sda_in;
                    else if (rx_phase)
                        sh <= {sh[6:0], sda_in};
                end
                if (bit_end) begin
                    case (state)
                        ST_START: state <= ST_ADDR;
                        ST_ADDR, ST_DATA: begin
                            if (bit_cnt != 4'd8) begin
                                bit_cnt <= bit_cnt + 4'd1;
                            end else if (state == ST_ADDR) begin
                                bit_cnt <= 4'd0;
                                if (ack_n) begin
                                    err   <= 1'b1;  // address refused
                                    state <= ST_STOP;
                                end else begin
                                    state  <= ST_DATA;
                                    tx_pop <= !rd_q;
                                end
                            end else begin
                                bit_cnt <= 4'd0;
                                rx_push <= rd_q;
                                if (!rd_q && ack_n && left != 16'd0)
                                    err <= 1'b1;    // early nack on write
                                if (left == 16'd0 || (!rd_q && ack_n)) begin
                                    state <= ST_STOP;
                                end else begin
                                    left   <= left - 16'd1;
                                    tx_pop <= !rd_q;
                                end
                            end
                        end
                        ST_STOP: begin
                            state    <= ST_IDLE;
                            cmd_done <= 1'b1;
                        end
                        default: state <= ST_IDLE;
                    endcase
                end
            end
        end
    end

endmodule

//--- design/i2c_ctrl_regs.sv
`timescale 1ns/100ps
`include "i2c_axi_settings.svh"

module i2c_ctrl_regs (
    input  logic                  clk,
    input  logic                  I2C_MASTER_AXI_SLAVE_RSTN_SYNC,
    reg_wr_if.regs                wr,
    reg_rd_if.regs                rd,
    output i2c_axi_pkg::i2c_cmd_t cmd,
    output logic                  cmd_valid,
    input  logic                  cmd_ready,
    input  logic                  cmd_done,
    input  logic                  cmd_error,
    input  logic                  tx_pop,
    output logic [7:0]            tx_byte,
    input  logic                  rx_push,
    input  logic [7:0]            rx_byte
);

    logic [6:0]  slave_addr;
    logic        read;
    logic        start;
    logic [15:0] length;
    logic        done_flag;
    logic        err_flag;
    logic        wr_setup0;
    logic        wr_setup1;
    logic        new_start;
    logic [7:0]  rx_data;

    assign wr_setup0 = wr.wr_en && (wr.wr_addr == `ADDR_SETUP0);
    assign wr_setup1 = wr.wr_en && (wr.wr_addr == `ADDR_SETUP1);
    assign new_start = wr_setup0 && wr.wr_strb[3] && wr.wr_data[24];

    assign cmd_valid = start;
    assign cmd       = '{slave_addr: slave_addr, read: read, length: length};

    always_ff @(posedge clk or negedge I2C_MASTER_AXI_SLAVE_RSTN_SYNC) begin
        if (!I2C_MASTER_AXI_SLAVE_RSTN_SYNC) begin
            slave_addr <= 7'd0;
            read       <= 1'b0;
            start      <= 1'b0;
            length     <= 16'd0;
            done_flag  <= 1'b0;
            err_flag   <= 1'b0;
        end else begin
            if (cmd_valid && cmd_ready)
                start <= 1'b0;          // self clearing once taken
            if (wr_setup0 && wr.wr_strb[0])
                slave_addr <= wr.wr_data[6:0];
            if (wr_setup0 && wr.wr_strb[1])
                read <= wr.wr_data[8];
            if (wr_setup0 && wr.wr_strb[3])
                start <= wr.wr_data[24];
            if (wr_setup1 && wr.wr_strb[0])
                length[7:0] <= wr.wr_data[7:0];
            if (wr_setup1 && wr.wr_strb[1])
                length[15:8] <= wr.wr_data[15:8];
            if (new_start) begin
                done_flag <= 1'b0;
                err_flag  <= 1'b0;
            end else if (cmd_done) begin
                done_flag <= 1'b1;
                err_flag  <= cmd_error;
            end
        end
    end

    always_comb begin
        case (rd.rd_addr)
            `ADDR_SETUP0:  rd.rd_data = {7'd0, start, 15'd0, read, 1'b0, slave_addr};
            `ADDR_SETUP1:  rd.rd_data = {16'd0, length};
            `ADDR_FLAG:    rd.rd_data = {23'd0, err_flag, 7'd0, done_flag};
            `ADDR_FIFO_RD: rd.rd_data = {24'd0, rx_data};
            default:       rd.rd_data = 32'd0;  // FIFO_WR is write only
        endcase
    end

    i2c_byte_fifo u_tx_fifo (
        .clk                            (clk),
        .I2C_MASTER_AXI_SLAVE_RSTN_SYNC (I2C_MASTER_AXI_SLAVE_RSTN_SYNC),
        .push      (wr.wr_en && (wr.wr_addr == `ADDR_FIFO_WR)),
        .push_data (wr.wr_data[7:0]),
        .pop       (tx_pop),
        .pop_data  (tx_byte),
        .full      (wr.tx_full),
        .empty     ()
    );

    i2c_byte_fifo u_rx_fifo (
        .clk                            (clk),
        .I2C_MASTER_AXI_SLAVE_RSTN_SYNC (I2C_MASTER_AXI_SLAVE_RSTN_SYNC),
        .push      (rx_push),
        .push_data (rx_byte),
        .pop       (rd.rd_pop),
        .pop_data  (rx_data),
        .full      (),
        .empty     (rd.rx_empty)
    );

endmodule

//--- design/i2c_master_axi_top.sv
`timescale 1ns/100ps

module i2c_master_axi_top (
    input  logic        clk,
    input  logic        I2C_MASTER_AXI_SLAVE_RSTN_SYNC,
    input  logic [3:0]  awid,
    input  logic [31:0] awaddr,
    input  logic [1:0]  awburst,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wlast,
    input  logic        wvalid,
    output logic        wready,
    output logic [3:0]  bid,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  arid,
    input  logic [31:0] araddr,
    input  logic [7:0]  arlen,
    input  logic [1:0]  arburst,
    input  logic        arvalid,
    output logic        arready,
    output logic [3:0]  rid,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready,
    output logic        scl_out,
    output logic        scl_enable,
    input  logic        sda_in,
    output logic        sda_out,
    output logic        sda_enable
);

    i2c_axi_pkg::i2c_cmd_t cmd;
    logic       cmd_valid;
    logic       cmd_ready;
    logic       cmd_done;
    logic       cmd_error;
    logic       tx_pop;
    logic [7:0] tx_byte;
    logic       rx_push;
    logic [7:0] rx_byte;

    reg_wr_if u_wr_if ();
    reg_rd_if u_rd_if ();

    // AXI write side into the register file
    axi_wr_channel u_axi_wr_channel (
        .wr (u_wr_if.chan),
        .*
    );

    // AXI read side out of the register file
    axi_rd_channel u_axi_rd_channel (
        .rd (u_rd_if.chan),
        .*
    );

    i2c_ctrl_regs u_i2c_ctrl_regs (
        .wr (u_wr_if.regs),
        .rd (u_rd_if.regs),
        .*
    );

    i2c_byte_engine u_i2c_byte_engine (.*);

endmodule

//--- dv/i2c_axi_checker.sv
`timescale 1ns/100ps

module i2c_axi_checker (
    input logic        clk,
    input logic        I2C_MASTER_AXI_SLAVE_RSTN_SYNC,
    input logic [3:0]  bid,
    input logic [1:0]  bresp,
    input logic        bvalid,
    input logic        bready,
    input logic [3:0]  rid,
    input logic [31:0] rdata,
    input logic [1:0]  rresp,
    input logic        rlast,
    input logic        rvalid,
    input logic        rready,
    input logic        scl,
    input logic        sda
);

    int         err_value;
    int         err_hold;
    int         err_bus;
    logic [8:0] exp_q[$];   // {byte, ack bit}
    logic [8:0] shift;
    int         nbits;
    logic       scl_q;
    logic       sda_q;
    logic       b_wait;     // response stalled last cycle
    logic       r_wait;
    logic [5:0] b_seen;
    logic [38:0] r_seen;

    initial begin
        err_value = 0;
        err_hold  = 0;
        err_bus   = 0;
        nbits     = 0;
        shift     = '0;
        scl_q     = 1'b1;
        sda_q     = 1'b1;
        b_wait    = 1'b0;
        r_wait    = 1'b0;
    end

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            err_value++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(input string what, input logic [1:0] got,
                              input i2c_axi_pkg::axi_resp_t exp);
        check_value(what, {30'd0, got}, {30'd0, exp});
    endtask

    task automatic expect_byte(input logic [7:0] b, input logic ack_n);
        exp_q.push_back({b, ack_n});
    endtask

    task automatic check_drained();
        if (exp_q.size() != 0) begin
            err_bus++;
            $display("ERR %0t: %0d expected bus bytes never appeared", $time, exp_q.size());
            exp_q.delete();
        end
    endtask

    // responses must hold while stalled
    always @(posedge clk) begin
        if (b_wait && (!bvalid || {bid, bresp} !== b_seen)) begin
            err_hold++;
            $display("ERR %0t: write response changed while stalled", $time);
        end
        if (r_wait && (!rvalid || {rid, rdata, rresp, rlast} !== r_seen)) begin
            err_hold++;
            $display("ERR %0t: read beat changed while stalled", $time);
        end
        b_wait = I2C_MASTER_AXI_SLAVE_RSTN_SYNC && bvalid && !bready;
        r_wait = I2C_MASTER_AXI_SLAVE_RSTN_SYNC && rvalid && !rready;
        b_seen = {bid, bresp};
        r_seen = {rid, rdata, rresp, rlast};
    end

    // bus decode, 8 data bits then ack
    always @(posedge clk) begin
        if (scl_q && scl && sda_q && !sda) begin
            nbits = 0;          // start
        end else if (!scl_q && scl) begin
            shift = {shift[7:0], sda};
            nbits++;
            if (nbits == 9) begin
                nbits = 0;
                if (exp_q.size() == 0) begin
                    err_bus++;
                    $display("ERR %0t: unexpected bus byte %h", $time, shift[8:1]);
                end else begin
                    check_value("bus byte and ack", {23'd0, shift}, {23'd0, exp_q[0]});
                    void'(exp_q.pop_front());
                end
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

//--- dv/tb_top.sv
`timescale 1ns/100ps
`include "i2c_axi_settings.svh"

module tb_top;

    localparam int N = 4;

    logic        clk;
    logic        I2C_MASTER_AXI_SLAVE_RSTN_SYNC;
    logic [3:0]  awid;
    logic [31:0] awaddr;
    logic [1:0]  awburst;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wlast;
    logic        wvalid;
    logic        wready;
    logic [3:0]  bid;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  arid;
    logic [31:0] araddr;
    logic [7:0]  arlen;
    logic [1:0]  arburst;
    logic        arvalid;
    logic        arready;
    logic [3:0]  rid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rlast;
    logic        rvalid;
    logic        rready;
    logic        scl_out;
    logic        scl_enable;
    logic        sda_out;
    logic        sda_enable;
    logic        sda_drv;       // slave side, pulled up when released
    wire         scl_bus = scl_enable ? scl_out : 1'b1;
    wire         sda_bus = sda_enable ? sda_out : sda_drv;

    // stimulus table
    logic [6:0]  t_addr [N] = '{7'h50, 7'h50, 7'h21, 7'h3a};
    logic        t_rd   [N] = '{1'b0, 1'b1, 1'b1, 1'b1};
    int          t_len  [N] = '{3, 4, 2, 1};
    logic        t_ack  [N] = '{1'b1, 1'b1, 1'b0, 1'b1};
    logic [7:0]  t_data [N][`I2C_FIFO_DEPTH];

    logic [31:0] wr_q[$];
    logic [31:0] rd_q[$];
    int          cur;
    int          cycles;
    int          limit;
    int          k;             // scl rises since start
    logic        scl_q;
    logic        sda_q;
    logic [31:0] sh0;
    logic [31:0] sh1;

    i2c_master_axi_top u_i2c_master_axi_top (.sda_in(sda_bus), .*);

    i2c_axi_checker u_checker (.scl(scl_bus), .sda(sda_bus), .*);

    always #20 clk = ~clk;

    // timeout guard
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run exceeded %0d cycles without finishing", limit);
            $display("Something failed");
            $finish;
        end
    end

    // slave model, drives its next bit after scl falls
    always @(posedge clk) begin
        if (scl_q && scl_bus && sda_q && !sda_bus) begin
            k = 0;
            sda_drv <= #2 1'b1;
        end else if (scl_q && !scl_bus) begin
            if (k / 9 == 0)
                sda_drv <= #2 (k % 9 == 8) ? !t_ack[cur] : 1'b1;
            else if (!t_ack[cur] || k / 9 > t_len[cur])
                sda_drv <= #2 1'b1;         // released after the transfer
            else if (!t_rd[cur])
                sda_drv <= #2 (k % 9 != 8);
            else if (k % 9 == 8)
                sda_drv <= #2 1'b1;         // master acks
            else
                sda_drv <= #2 t_data[cur][k / 9 - 1][7 - k % 9];
        end else if (!scl_q && scl_bus) begin
            k++;
        end
        scl_q = scl_bus;
        sda_q = sda_bus;
    end

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] d,
                                          input logic [3:0] strb);
        logic [31:0] m;
        m = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old & ~m) | (d & m);
    endfunction

    task automatic axi_write(input logic [3:0] id, input logic [31:0] addr,
                             input logic [1:0] burst, input logic [3:0] strb,
                             input i2c_axi_pkg::axi_resp_t exp);
        int n;
        n = wr_q.size();
        {awid, awaddr, awburst, awvalid} = {id, addr, burst, 1'b1};
        do @(posedge clk); while (!awready);
        #2 awvalid = 1'b0;
        for (int i = 0; i < n; i++) begin
            {wdata, wstrb, wlast, wvalid} = {wr_q[i], strb, i == n - 1, 1'b1};
            do @(posedge clk); while (!wready);
            #2 wvalid = 1'b0;
        end
        repeat ($urandom_range(0, 3)) @(posedge clk);
        #2 bready = 1'b1;
        do @(posedge clk); while (!bvalid);
        u_checker.check_value("bid", {28'd0, bid}, {28'd0, id});
        u_checker.check_resp("bresp", bresp, exp);
        #2 bready = 1'b0;
        wr_q.delete();
    endtask

    task automatic axi_read(input logic [3:0] id, input logic [31:0] addr, input int len,
                            input logic [1:0] burst, input i2c_axi_pkg::axi_resp_t exp);
        rd_q.delete();
        {arid, araddr, arlen, arburst, arvalid} = {id, addr, 8'(len), burst, 1'b1};
        do @(posedge clk); while (!arready);
        #2 arvalid = 1'b0;
        for (int i = 0; i <= len; i++) begin
            repeat ($urandom_range(0, 3)) @(posedge clk);
            #2 rready = 1'b1;
            do @(posedge clk); while (!rvalid);
            rd_q.push_back(rdata);
            u_checker.check_value("rid", {28'd0, rid}, {28'd0, id});
            u_checker.check_value("rlast", {31'd0, rlast}, {31'd0, i == len});
            u_checker.check_resp("rresp", rresp, exp);
            #2 rready = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(32'h1eab0e67));
        {clk, awid, awaddr, awburst, awvalid, wdata, wstrb, wlast, wvalid, bready} = '0;
        {arid, araddr, arlen, arburst, arvalid, rready} = '0;
        I2C_MASTER_AXI_SLAVE_RSTN_SYNC = 1'b0;
        {sda_drv, scl_q, sda_q} = 3'b111;
        {cycles, cur, k} = '0;
        limit = 600;
        for (int i = 0; i < N; i++) begin
            limit += 9 * (t_len[i] + 1) * 4 * `I2C_CLK_DIV + 200;
            for (int j = 0; j < `I2C_FIFO_DEPTH; j++)
                t_data[i][j] = 8'($urandom);
        end
        repeat (2) @(posedge clk);
        #2 I2C_MASTER_AXI_SLAVE_RSTN_SYNC = 1'b1;

        // partial strobe readback, dropped fields read zero
        sh0 = merge(32'd0, 32'h00aa_ffd5, 4'b0011) & 32'h0000_017f;
        wr_q.push_back(32'h00aa_ffd5);
        axi_write(4'h1, `ADDR_SETUP0, i2c_axi_pkg::BURST_FIXED, 4'b0011, i2c_axi_pkg::RESP_OKAY);
        sh0 = merge(sh0, 32'h0000_00a3, 4'b0001) & 32'h0000_017f;
        wr_q.push_back(32'h0000_00a3);
        axi_write(4'h2, `ADDR_SETUP0, i2c_axi_pkg::BURST_FIXED, 4'b0001, i2c_axi_pkg::RESP_OKAY);
        sh1 = merge(32'd0, 32'hdead_beef, 4'b1111) & 32'h0000_ffff;
        wr_q.push_back(32'hdead_beef);
        axi_write(4'h3, `ADDR_SETUP1, i2c_axi_pkg::BURST_FIXED, 4'b1111, i2c_axi_pkg::RESP_OKAY);
        sh1 = merge(sh1, 32'h1234_5600, 4'b0010) & 32'h0000_ffff;
        wr_q.push_back(32'h1234_5600);
        axi_write(4'h4, `ADDR_SETUP1, i2c_axi_pkg::BURST_FIXED, 4'b0010, i2c_axi_pkg::RESP_OKAY);
        axi_read(4'h5, `ADDR_SETUP0, 1, i2c_axi_pkg::BURST_INCR, i2c_axi_pkg::RESP_OKAY);
        u_checker.check_value("setup0 readback", rd_q[0], sh0);
        u_checker.check_value("setup1 readback", rd_q[1], sh1);

        // out of range addresses
        wr_q.push_back(32'h0000_00ff);
        axi_write(4'h7, 32'd5, i2c_axi_pkg::BURST_FIXED, 4'b1111, i2c_axi_pkg::RESP_SLVERR);
        axi_read(4'h9, 32'd6, 2, i2c_axi_pkg::BURST_INCR, i2c_axi_pkg::RESP_SLVERR);
        foreach (rd_q[i])
            u_checker.check_value("error read data", rd_q[i], 32'd0);

        foreach (t_addr[i]) begin
            cur = i;
            if (!t_rd[i]) begin
                for (int j = 0; j < t_len[i]; j++)
                    wr_q.push_back({24'd0, t_data[i][j]});
                axi_write(4'ha, `ADDR_FIFO_WR, i2c_axi_pkg::BURST_FIXED, 4'b0001,
                          i2c_axi_pkg::RESP_OKAY);
            end
            u_checker.expect_byte({t_addr[i], t_rd[i]}, !t_ack[i]);
            for (int j = 0; j < t_len[i] && t_ack[i]; j++)
                u_checker.expect_byte(t_data[i][j], t_rd[i] && j == t_len[i] - 1);
            wr_q.push_back(32'(t_len[i] - 1));
            axi_write(4'hb, `ADDR_SETUP1, i2c_axi_pkg::BURST_FIXED, 4'b0011,
                      i2c_axi_pkg::RESP_OKAY);
            wr_q.push_back(32'h0100_0000 | {23'd0, t_rd[i], 1'b0, t_addr[i]});
            axi_write(4'hc, `ADDR_SETUP0, i2c_axi_pkg::BURST_FIXED, 4'b1011,
                      i2c_axi_pkg::RESP_OKAY);
            do axi_read(4'hd, `ADDR_FLAG, 0, i2c_axi_pkg::BURST_FIXED, i2c_axi_pkg::RESP_OKAY);
            while (!rd_q[0][0]);
            u_checker.check_value("flag after done", rd_q[0], t_ack[i] ? 32'h1 : 32'h101);
            u_checker.check_drained();
            if (t_rd[i] && t_ack[i]) begin
                axi_read(4'he, `ADDR_FIFO_RD, t_len[i] - 1, i2c_axi_pkg::BURST_FIXED,
                         i2c_axi_pkg::RESP_OKAY);
                foreach (rd_q[j])
                    u_checker.check_value("rx fifo byte", rd_q[j], {24'd0, t_data[i][j]});
            end
        end

        repeat (4) @(posedge clk);
        $display("errors: value=%0d hold=%0d bus=%0d", u_checker.err_value,
                 u_checker.err_hold, u_checker.err_bus);
        if (u_checker.err_value + u_checker.err_hold + u_checker.err_bus == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

//--- files.f
+incdir+include
design/i2c_axi_pkg.sv
design/i2c_axi_if.sv
design/i2c_byte_fifo.sv
design/axi_wr_channel.sv
design/axi_rd_channel.sv
design/i2c_byte_engine.sv
design/i2c_ctrl_regs.sv
design/i2c_master_axi_top.sv
dv/i2c_axi_checker.sv
dv/tb_top.sv
